// ==== riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

    // Major opcode, inst[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD      = 5'b00000,
        OPC_ARI_ITYPE = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_STORE     = 5'b01000,
        OPC_ARI_RTYPE = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_BRANCH    = 5'b11000,
        OPC_JALR      = 5'b11001,
        OPC_JAL       = 5'b11011
    } opcode_e;

    // ALU funct3
    localparam logic [2:0] FNC_ADD_SUB = 3'b000;
    localparam logic [2:0] FNC_SLL     = 3'b001;
    localparam logic [2:0] FNC_SLT     = 3'b010;
    localparam logic [2:0] FNC_SLTU    = 3'b011;
    localparam logic [2:0] FNC_XOR     = 3'b100;
    localparam logic [2:0] FNC_SRL_SRA = 3'b101;
    localparam logic [2:0] FNC_OR      = 3'b110;
    localparam logic [2:0] FNC_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] FNC_BEQ  = 3'b000;
    localparam logic [2:0] FNC_BNE  = 3'b001;
    localparam logic [2:0] FNC_BLT  = 3'b100;
    localparam logic [2:0] FNC_BGE  = 3'b101;
    localparam logic [2:0] FNC_BLTU = 3'b110;
    localparam logic [2:0] FNC_BGEU = 3'b111;

    // Instruction bit 30
    localparam logic FNC2_ADD = 1'b0;
    localparam logic FNC2_SUB = 1'b1;
    localparam logic FNC2_SRL = 1'b0;
    localparam logic FNC2_SRA = 1'b1;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_t;

endpackage

`default_nettype wire

// ==== ex_types_pkg.sv ====
`default_nettype none

package ex_types_pkg;

    typedef enum logic {
        A_REG,
        A_PC
    } asel_e;

    typedef enum logic {
        B_REG,
        B_IMM
    } bsel_e;

    typedef enum logic {
        FWD_REG,
        FWD_PREV
    } fwd_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        riscv_isa_pkg::inst_t inst;
        logic [31:0]          pc;
        logic [31:0]          rs1_val;
        logic [31:0]          rs2_val;
    } ex_issue_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] wdata;
        logic [31:0] alu_out;
        logic        redirect;
    } ex_result_t;

    // Queue depth doubles as the upstream credit count
    localparam int ISSUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;

    localparam int CREDIT_MAX  = (ISSUE_DEPTH > OUT_CREDITS) ? ISSUE_DEPTH : OUT_CREDITS;
    localparam int ISSUE_PTR_W = $clog2(ISSUE_DEPTH);

    typedef logic [$clog2(CREDIT_MAX + 1)-1:0] credit_cnt_t;
    typedef logic [ISSUE_PTR_W-1:0] issue_ptr_t;

    localparam issue_ptr_t ISSUE_LAST = issue_ptr_t'(ISSUE_DEPTH - 1);

endpackage

`default_nettype wire

// ==== ex_issue_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_issue_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  ex_types_pkg::ex_issue_t push_data,
    input  logic                    pop,
    output ex_types_pkg::ex_issue_t head,
    output logic                    not_empty
);

    ex_types_pkg::ex_issue_t   mem [ex_types_pkg::ISSUE_DEPTH];
    ex_types_pkg::issue_ptr_t  wr_ptr;
    ex_types_pkg::issue_ptr_t  rd_ptr;
    ex_types_pkg::credit_cnt_t count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ex_types_pkg::ISSUE_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ex_types_pkg::ISSUE_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

`default_nettype wire

// ==== ex_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_control (
    input  logic                  clk,
    input  logic                  rst,
    input  riscv_isa_pkg::inst_t  inst,
    input  logic                  not_empty,
    input  logic                  out_credit,
    input  logic                  breq,
    input  logic                  brlt,
    output logic                  pop,
    output logic                  brun,
    output ex_types_pkg::fwd_e    fwda,
    output ex_types_pkg::fwd_e    fwdb,
    output ex_types_pkg::asel_e   asel,
    output ex_types_pkg::bsel_e   bsel,
    output ex_types_pkg::alu_op_e alusel,
    output logic                  rd_we,
    output logic                  is_jump,
    output logic                  redirect
);

    riscv_isa_pkg::opcode_e    opcode5;
    logic                      writes_rd;
    logic                      is_branch;
    logic                      br_taken;
    logic [4:0]                last_rd;
    logic                      last_we;
    ex_types_pkg::credit_cnt_t credits;

    assign opcode5 = riscv_isa_pkg::opcode_e'(inst.opcode[6:2]);

    always_comb begin
        asel      = ex_types_pkg::A_REG;
        bsel      = ex_types_pkg::B_REG;
        alusel    = ex_types_pkg::ALU_ADD;
        brun      = 1'b0;
        writes_rd = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        case (opcode5)
            riscv_isa_pkg::OPC_ARI_RTYPE, riscv_isa_pkg::OPC_ARI_ITYPE: begin
                writes_rd = 1'b1;
                if (opcode5 == riscv_isa_pkg::OPC_ARI_ITYPE) begin
                    bsel = ex_types_pkg::B_IMM;
                end
                case (inst.funct3)
                    riscv_isa_pkg::FNC_ADD_SUB: begin
                        // ADDI has no SUB form, bit 30 is part of its immediate
                        if (opcode5 == riscv_isa_pkg::OPC_ARI_RTYPE &&
                            inst.funct7[5] == riscv_isa_pkg::FNC2_SUB) begin
                            alusel = ex_types_pkg::ALU_SUB;
                        end
                    end
                    riscv_isa_pkg::FNC_SLL:  alusel = ex_types_pkg::ALU_SLL;
                    riscv_isa_pkg::FNC_SLT:  alusel = ex_types_pkg::ALU_SLT;
                    riscv_isa_pkg::FNC_SLTU: begin
                        alusel = ex_types_pkg::ALU_SLTU;
                        brun   = 1'b1;
                    end
                    riscv_isa_pkg::FNC_XOR:  alusel = ex_types_pkg::ALU_XOR;
                    riscv_isa_pkg::FNC_SRL_SRA: begin
                        alusel = (inst.funct7[5] == riscv_isa_pkg::FNC2_SRA) ?
                                 ex_types_pkg::ALU_SRA : ex_types_pkg::ALU_SRL;
                    end
                    riscv_isa_pkg::FNC_OR:   alusel = ex_types_pkg::ALU_OR;
                    default:                 alusel = ex_types_pkg::ALU_AND;
                endcase
            end
            riscv_isa_pkg::OPC_LOAD: begin
                bsel      = ex_types_pkg::B_IMM;
                writes_rd = 1'b1;
            end
            riscv_isa_pkg::OPC_STORE: begin
                bsel = ex_types_pkg::B_IMM;
            end
            riscv_isa_pkg::OPC_BRANCH: begin
                asel      = ex_types_pkg::A_PC;
                bsel      = ex_types_pkg::B_IMM;
                is_branch = 1'b1;
                brun      = (inst.funct3 == riscv_isa_pkg::FNC_BLTU) ||
                            (inst.funct3 == riscv_isa_pkg::FNC_BGEU);
            end
            riscv_isa_pkg::OPC_JAL: begin
                asel      = ex_types_pkg::A_PC;
                bsel      = ex_types_pkg::B_IMM;
                writes_rd = 1'b1;
                is_jump   = 1'b1;
            end
            riscv_isa_pkg::OPC_JALR: begin
                bsel      = ex_types_pkg::B_IMM;
                writes_rd = 1'b1;
                is_jump   = 1'b1;
            end
            riscv_isa_pkg::OPC_LUI: begin
                bsel      = ex_types_pkg::B_IMM;
                alusel    = ex_types_pkg::ALU_PASS_B;
                writes_rd = 1'b1;
            end
            riscv_isa_pkg::OPC_AUIPC: begin
                asel      = ex_types_pkg::A_PC;
                bsel      = ex_types_pkg::B_IMM;
                writes_rd = 1'b1;
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (inst.funct3)
            riscv_isa_pkg::FNC_BEQ:  br_taken = breq;
            riscv_isa_pkg::FNC_BNE:  br_taken = !breq;
            riscv_isa_pkg::FNC_BLT,
            riscv_isa_pkg::FNC_BLTU: br_taken = brlt;
            riscv_isa_pkg::FNC_BGE,
            riscv_isa_pkg::FNC_BGEU: br_taken = !brlt;
            default:                 br_taken = 1'b0;
        endcase
    end

    assign redirect = is_jump || (is_branch && br_taken);
    assign rd_we    = writes_rd && (inst.rd != 5'd0);

    // last_we is never set for x0
    assign fwda = (last_we && inst.rs1 == last_rd) ? ex_types_pkg::FWD_PREV
                                                   : ex_types_pkg::FWD_REG;
    assign fwdb = (last_we && inst.rs2 == last_rd) ? ex_types_pkg::FWD_PREV
                                                   : ex_types_pkg::FWD_REG;

    assign pop = not_empty && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= ex_types_pkg::credit_cnt_t'(ex_types_pkg::OUT_CREDITS);
            last_we <= 1'b0;
        end else begin
            case ({pop, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if (pop) begin
                last_we <= rd_we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            last_rd <= inst.rd;
        end
    end

endmodule

`default_nettype wire

// ==== ex_operand_sel.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_operand_sel (
    input  ex_types_pkg::ex_issue_t issue,
    input  logic [31:0]             prev_wdata,
    input  ex_types_pkg::fwd_e      fwda,
    input  ex_types_pkg::fwd_e      fwdb,
    input  ex_types_pkg::asel_e     asel,
    input  ex_types_pkg::bsel_e     bsel,
    output logic [31:0]             op_a,
    output logic [31:0]             op_b,
    output logic [31:0]             rs1_fwd,
    output logic [31:0]             rs2_fwd
);

    riscv_isa_pkg::inst_t inst;
    logic [31:0]          imm;

    assign inst = issue.inst;

    always_comb begin
        case (riscv_isa_pkg::opcode_e'(inst.opcode[6:2]))
            riscv_isa_pkg::OPC_STORE:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            riscv_isa_pkg::OPC_BRANCH:
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC:
                imm = {inst[31:12], 12'b0};
            riscv_isa_pkg::OPC_JAL:
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            // I-type for ALU immediates, loads and JALR
            default:
                imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    assign rs1_fwd = (fwda == ex_types_pkg::FWD_PREV) ? prev_wdata : issue.rs1_val;
    assign rs2_fwd = (fwdb == ex_types_pkg::FWD_PREV) ? prev_wdata : issue.rs2_val;

    assign op_a = (asel == ex_types_pkg::A_PC)  ? issue.pc : rs1_fwd;
    assign op_b = (bsel == ex_types_pkg::B_IMM) ? imm      : rs2_fwd;

endmodule

`default_nettype wire

// ==== ex_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
    input  logic [31:0]           op_a,
    input  logic [31:0]           op_b,
    input  logic [31:0]           cmp_a,
    input  logic [31:0]           cmp_b,
    input  ex_types_pkg::alu_op_e alusel,
    input  logic                  brun,
    output logic [31:0]           alu_out,
    output logic                  breq,
    output logic                  brlt
);

    logic [4:0] shamt;
    logic       lt_ab;
    logic       ltu_ab;

    assign shamt  = op_b[4:0];
    assign ltu_ab = (op_a < op_b);
    // brun picks unsigned compare
    assign lt_ab  = brun ? ltu_ab : ($signed(op_a) < $signed(op_b));

    always_comb begin
        case (alusel)
            ex_types_pkg::ALU_ADD:    alu_out = op_a + op_b;
            ex_types_pkg::ALU_SUB:    alu_out = op_a - op_b;
            ex_types_pkg::ALU_AND:    alu_out = op_a & op_b;
            ex_types_pkg::ALU_OR:     alu_out = op_a | op_b;
            ex_types_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            ex_types_pkg::ALU_SLL:    alu_out = op_a << shamt;
            ex_types_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            ex_types_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            ex_types_pkg::ALU_SLT:    alu_out = {31'b0, lt_ab};
            ex_types_pkg::ALU_SLTU:   alu_out = {31'b0, ltu_ab};
            ex_types_pkg::ALU_PASS_B: alu_out = op_b;
            default:                  alu_out = 32'b0;
        endcase
    end

    // Branch flags from the forwarded register values
    assign breq = (cmp_a == cmp_b);
    assign brlt = brun ? (cmp_a < cmp_b) : ($signed(cmp_a) < $signed(cmp_b));

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  ex_types_pkg::ex_issue_t  in_issue,
    input  logic                     out_credit,
    output logic                     in_credit,
    output logic                     out_valid,
    output ex_types_pkg::ex_result_t out_result
);

    logic                     in_valid_q;
    ex_types_pkg::ex_issue_t  in_issue_q;
    ex_types_pkg::ex_issue_t  head;
    logic                     not_empty;
    logic                     pop;
    logic                     brun;
    logic                     breq;
    logic                     brlt;
    logic                     rd_we;
    logic                     is_jump;
    logic                     redirect;
    ex_types_pkg::fwd_e       fwda;
    ex_types_pkg::fwd_e       fwdb;
    ex_types_pkg::asel_e      asel;
    ex_types_pkg::bsel_e      bsel;
    ex_types_pkg::alu_op_e    alusel;
    logic [31:0]              op_a;
    logic [31:0]              op_b;
    logic [31:0]              rs1_fwd;
    logic [31:0]              rs2_fwd;
    logic [31:0]              alu_out;
    ex_types_pkg::ex_result_t result_d;

    // Input register ahead of the queue
    always_ff @(posedge clk) begin
        if (rst) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        in_issue_q <= in_issue;
    end

    ex_issue_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (in_valid_q),
        .push_data (in_issue_q),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty)
    );

    ex_control u_control (
        .clk        (clk),
        .rst        (rst),
        .inst       (head.inst),
        .not_empty  (not_empty),
        .out_credit (out_credit),
        .breq       (breq),
        .brlt       (brlt),
        .pop        (pop),
        .brun       (brun),
        .fwda       (fwda),
        .fwdb       (fwdb),
        .asel       (asel),
        .bsel       (bsel),
        .alusel     (alusel),
        .rd_we      (rd_we),
        .is_jump    (is_jump),
        .redirect   (redirect)
    );

    // Held result is the forwarding source until the next pop
    ex_operand_sel u_operand_sel (
        .issue      (head),
        .prev_wdata (out_result.wdata),
        .fwda       (fwda),
        .fwdb       (fwdb),
        .asel       (asel),
        .bsel       (bsel),
        .op_a       (op_a),
        .op_b       (op_b),
        .rs1_fwd    (rs1_fwd),
        .rs2_fwd    (rs2_fwd)
    );

    ex_alu u_alu (
        .op_a    (op_a),
        .op_b    (op_b),
        .cmp_a   (rs1_fwd),
        .cmp_b   (rs2_fwd),
        .alusel  (alusel),
        .brun    (brun),
        .alu_out (alu_out),
        .breq    (breq),
        .brlt    (brlt)
    );

    always_comb begin
        result_d.rd       = head.inst.rd;
        result_d.rd_we    = rd_we;
        result_d.wdata    = is_jump ? head.pc + 32'd4 : alu_out;
        result_d.alu_out  = alu_out;
        result_d.redirect = redirect;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_result <= result_d;
        end
    end

    // Upstream credit goes back with the popped entry's result
    assign in_credit = out_valid;

endmodule

`default_nettype wire

// ==== ex_stage_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage_asserts (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input logic out_credit,
    input logic out_valid,
    input logic in_credit
);

    ex_types_pkg::credit_cnt_t credits;
    ex_types_pkg::credit_cnt_t occupancy;
    int                        fail_count = 0;

    // Downstream credits as the consumer counts them, and queue fill
    always_ff @(posedge clk) begin
        if (rst) begin
            credits   <= ex_types_pkg::credit_cnt_t'(ex_types_pkg::OUT_CREDITS);
            occupancy <= '0;
        end else begin
            credits   <= credits - ex_types_pkg::credit_cnt_t'(out_valid)
                         + ex_types_pkg::credit_cnt_t'(out_credit);
            occupancy <= occupancy + ex_types_pkg::credit_cnt_t'(push)
                         - ex_types_pkg::credit_cnt_t'(pop);
        end
    end

    a_result_has_credit: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> credits != '0
    ) else begin
        $error("out_valid without a downstream credit");
        fail_count++;
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        push |-> occupancy != ex_types_pkg::credit_cnt_t'(ex_types_pkg::ISSUE_DEPTH)
    ) else begin
        $error("issue queue pushed while full");
        fail_count++;
    end

    a_quiet_in_reset: assert property (
        @(posedge clk) rst |=> (!out_valid && !in_credit)
    ) else begin
        $error("out_valid or in_credit high during reset");
        fail_count++;
    end

endmodule

bind ex_stage ex_stage_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .push       (in_valid_q),
    .pop        (pop),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .in_credit  (in_credit)
);

`default_nettype wire

// ==== tb_ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage;

    localparam int NUM_INSTS    = 25;
    localparam int STIM_WORDS   = 9;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int TAIL_CYCLES  = 12;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 40 * NUM_INSTS) * CLK_PERIOD;

    logic                     clk;
    logic                     rst;
    logic                     in_valid;
    ex_types_pkg::ex_issue_t  in_issue;
    logic                     out_credit;
    logic                     in_credit;
    logic                     out_valid;
    ex_types_pkg::ex_result_t out_result;

    logic [31:0]              stim_mem [NUM_INSTS * STIM_WORDS];
    ex_types_pkg::ex_issue_t  issue_list [NUM_INSTS];
    ex_types_pkg::ex_result_t expect_list [NUM_INSTS];

    int                       return_due [$];
    int unsigned              lcg_state;
    int                       cycle;
    int                       sent;
    int                       results;
    int                       credit_pulses;
    int                       up_credits;
    int                       dn_credits;

    ex_stage u_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_issue   (in_issue),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic string result_text(input ex_types_pkg::ex_result_t r);
        return $sformatf("{rd=%0d rd_we=%b wdata=%h alu_out=%h redirect=%b}",
                         r.rd, r.rd_we, r.wdata, r.alu_out, r.redirect);
    endfunction

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_result(input int idx, input ex_types_pkg::ex_result_t got,
                                input ex_types_pkg::ex_result_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: out_result[%0d] got %s expected %s",
                     $time, idx, result_text(got), result_text(exp));
            stop_with_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // Nine hex words per instruction, issue fields then expected result
    task automatic load_stimulus();
        int base;
        $readmemh("ex_stage_stim.txt", stim_mem);
        for (int i = 0; i < NUM_INSTS; i++) begin
            base = i * STIM_WORDS;
            if ($isunknown(stim_mem[base + 8]) || stim_mem[base] == 32'd0) begin
                $display("Stimulus file ex_stage_stim.txt is missing or too short");
                stop_with_failure();
            end
            issue_list[i].inst     = stim_mem[base];
            issue_list[i].pc       = stim_mem[base + 1];
            issue_list[i].rs1_val  = stim_mem[base + 2];
            issue_list[i].rs2_val  = stim_mem[base + 3];
            expect_list[i].rd       = stim_mem[base + 4][4:0];
            expect_list[i].rd_we    = stim_mem[base + 5][0];
            expect_list[i].wdata    = stim_mem[base + 6];
            expect_list[i].alu_out  = stim_mem[base + 7];
            expect_list[i].redirect = stim_mem[base + 8][0];
        end
    endtask

    // One falling edge: sample outputs, return credits, send the next instruction
    task automatic service_cycle();
        int delay;
        if (u_dut.u_asserts.fail_count != 0) begin
            $display("A bound assertion on ex_stage failed before %0t ns", $time);
            stop_with_failure();
        end
        if (in_credit) begin
            credit_pulses++;
            up_credits++;
        end
        if (out_valid) begin
            if (results >= NUM_INSTS) begin
                $display("ex_stage sent a result with no instruction left to execute");
                stop_with_failure();
            end
            if (dn_credits == 0) begin
                $display("ex_stage sent a result while holding no downstream credit");
                stop_with_failure();
            end
            check_result(results, out_result, expect_list[results]);
            results++;
            dn_credits--;
            lcg_state = lcg_next(lcg_state);
            delay = int'((lcg_state >> 16) % 6);
            return_due.push_back(cycle + delay);
        end
        if (return_due.size() > 0 && return_due[0] <= cycle) begin
            void'(return_due.pop_front());
            out_credit = 1'b1;
            dn_credits++;
        end else begin
            out_credit = 1'b0;
        end
        if (sent < NUM_INSTS && up_credits > 0) begin
            in_valid = 1'b1;
            in_issue = issue_list[sent];
            sent++;
            up_credits--;
        end else begin
            in_valid = 1'b0;
            in_issue = '0;
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_issue      = '0;
        out_credit    = 1'b0;
        lcg_state     = 32'd7068;
        cycle         = 0;
        sent          = 0;
        results       = 0;
        credit_pulses = 0;
        up_credits    = ex_types_pkg::ISSUE_DEPTH;
        dn_credits    = ex_types_pkg::OUT_CREDITS;
        load_stimulus();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Stage stays quiet until the first send
        repeat (4) begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_credit", in_credit, 1'b0);
        end

        while (results < NUM_INSTS) begin
            @(negedge clk);
            cycle++;
            service_cycle();
        end
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            cycle++;
            service_cycle();
        end

        check_count("results", results, NUM_INSTS);
        check_count("in_credit pulses", credit_pulses, NUM_INSTS);
        check_count("upstream credits", up_credits, ex_types_pkg::ISSUE_DEPTH);
        check_count("downstream credits", dn_credits, ex_types_pkg::OUT_CREDITS);

        if (u_dut.u_asserts.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Bound assertions on ex_stage reported %0d failures",
                     u_dut.u_asserts.fail_count);
            stop_with_failure();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d of %0d results received",
                 WATCHDOG_NS, results, NUM_INSTS);
        stop_with_failure();
    end

endmodule

`default_nettype wire

// ==== ex_stage_stim.txt ====
// inst pc rs1_val rs2_val | expected: rd rd_we wdata alu_out redirect (all hex)
// Stale rs1_val/rs2_val on dependent lines, expected values use the forwarded result
002081B3 00000100 00000010 00000025 03 1 00000035 00000035 0
40518233 00000104 DEADBEEF 00000040 04 1 FFFFFFF5 FFFFFFF5 0
40725333 00000108 12345678 00000022 06 1 FFFFFFFD FFFFFFFD 0
00A4D433 0000010C F0000000 00000004 08 1 0F000000 0F000000 0
00D625B3 00000110 FFFFFFFF 00000001 0B 1 00000001 00000001 0
00D63733 00000114 FFFFFFFF 00000001 0E 1 00000000 00000000 0
40885793 00000118 80001234 00000000 0F 1 FF800012 FF800012 0
0057B893 0000011C 00000000 00000000 11 1 00000000 00000000 0
FFF8C913 00000120 5555AAAA 00000000 12 1 FFFFFFFF FFFFFFFF 0
0129A623 00000124 00001000 CAFEF00D 0C 0 0000100C 0000100C 0
FFC62A03 00000128 00002000 00000000 14 1 00001FFC 00001FFC 0
001A0013 0000012C 00000000 00000000 00 0 00001FFD 00001FFD 0
01600AB3 00000130 00000000 00000077 15 1 00000077 00000077 0
ABCDEBB7 00000134 00000000 00000000 17 1 ABCDE000 ABCDE000 0
00012C17 00000138 00000000 00000000 18 1 00012138 00012138 0
00208863 0000013C 00001234 00001234 10 0 0000014C 0000014C 1
FE209CE3 00000140 00000055 00000055 19 0 00000138 00000138 0
0062C863 00000144 FFFFFFF0 00000003 10 0 00000154 00000154 1
FE62DCE3 00000148 FFFFFFF0 00000003 19 0 00000140 00000140 0
0062E863 0000014C FFFFFFF0 00000003 10 0 0000015C 0000015C 0
FE62FCE3 00000150 FFFFFFF0 00000003 19 0 00000148 00000148 1
100000EF 00000154 00000000 00000000 01 1 00000158 00000254 1
008082E7 00000158 00000000 00000000 05 1 0000015C 00000160 1
00029863 0000015C 00000000 00000000 10 0 0000016C 0000016C 1
01CDFD33 00000160 FF00FF00 0FF00FF0 1A 1 0F000F00 0F000F00 0

// ==== ex_stage.f ====
riscv_isa_pkg.sv
ex_types_pkg.sv
ex_issue_queue.sv
ex_control.sv
ex_operand_sel.sv
ex_alu.sv
ex_stage.sv
ex_stage_asserts.sv
tb_ex_stage.sv

// ==== Makefile ====
TOP = tb_ex_stage
OBJ = obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): ex_stage.f *.sv
	verilator --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ) -f ex_stage.f

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f ex_stage.f

clean:
	rm -rf $(OBJ) sim.log
